// File: src/fu_pkg.sv
package fu_pkg;

  parameter int DEFAULT_MULT_STAGES = 8;
  parameter int DEFAULT_ROB_DEPTH   = 32;

  typedef logic [63:0] word_t;    // data word on operands and the CDB
  typedef logic [4:0]  rob_idx_t; // ROB entry tag
  typedef logic [2:0]  br_cond_t; // {invert, test select}

  // which unit an issue packet targets and the ready bit index
  typedef enum logic [1:0] {
    KIND_ALU  = 2'd0,
    KIND_MULT = 2'd1,
    KIND_BR   = 2'd2
  } fu_kind_t;

  typedef enum logic [3:0] {
    ADDQ   = 4'd0,
    SUBQ   = 4'd1,
    AND    = 4'd2,
    BIC    = 4'd3,
    BIS    = 4'd4,
    ORNOT  = 4'd5,
    XOR    = 4'd6,
    EQV    = 4'd7,
    SRL    = 4'd8,
    SLL    = 4'd9,
    SRA    = 4'd10,
    CMPULT = 4'd11,
    CMPEQ  = 4'd12,
    CMPULE = 4'd13,
    CMPLT  = 4'd14,
    CMPLE  = 4'd15
  } alu_func_t;

  // true when tag lies between the rollback point and the tail in ring order
  function automatic logic rob_younger(rob_idx_t tag, rob_idx_t rollback_idx,
                                       rob_idx_t tail, int unsigned depth);
    int unsigned tag_dist;
    int unsigned tail_dist;
    tag_dist  = (32'(tag) + depth - 32'(rollback_idx)) % depth;
    tail_dist = (32'(tail) + depth - 32'(rollback_idx)) % depth;
    return tag_dist <= tail_dist;
  endfunction

endpackage

// File: src/fu_issue_if.sv
`timescale 1ns/10ps

interface fu_issue_if;
  logic                valid;
  fu_pkg::fu_kind_t    kind;
  fu_pkg::alu_func_t   func;
  fu_pkg::br_cond_t    br_cond;
  logic                uncond;
  fu_pkg::word_t       opa;
  fu_pkg::word_t       opb;
  fu_pkg::word_t       npc;
  fu_pkg::rob_idx_t    tag;
  wire  [2:0]          ready;  // one bit per unit, indexed by fu_kind_t

  modport source (
    output valid, kind, func, br_cond, uncond, opa, opb, npc, tag,
    input  ready
  );

  modport unit (
    input  valid, kind, func, br_cond, uncond, opa, opb, npc, tag,
    output ready
  );
endinterface

// File: src/fu_result_if.sv
`timescale 1ns/10ps

interface fu_result_if;
  logic             valid;
  logic             grant;
  fu_pkg::word_t    value;
  fu_pkg::rob_idx_t tag;
  logic             taken;  // branch unit only

  modport unit (
    output valid, value, tag, taken,
    input  grant
  );

  modport arbiter (
    input  valid, value, tag, taken,
    output grant
  );
endinterface

// File: src/alu_unit.sv
`timescale 1ns/10ps

module alu_unit #(
  parameter int ROB_DEPTH = fu_pkg::DEFAULT_ROB_DEPTH
) (
  input  logic             clock,
  input  logic             reset,
  fu_issue_if.unit         issue,
  fu_result_if.unit        result,
  input  logic             rollback_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  input  fu_pkg::rob_idx_t rob_tail
);

  logic             unit_ready;
  logic             accept;
  logic             kill_in;    // incoming packet is on the wrong path
  logic             kill_held;  // held result is on the wrong path
  logic             res_valid;
  fu_pkg::word_t    alu_out;
  fu_pkg::word_t    res_value;
  fu_pkg::rob_idx_t res_tag;

  // equal signs compare as unsigned and otherwise the negative one is less
  function automatic logic signed_lt(fu_pkg::word_t a, fu_pkg::word_t b);
    if (a[63] == b[63])
      return a < b;
    return a[63];
  endfunction

  always_comb begin
    case (issue.func)
      fu_pkg::ADDQ:   alu_out = issue.opa + issue.opb;
      fu_pkg::SUBQ:   alu_out = issue.opa - issue.opb;
      fu_pkg::AND:    alu_out = issue.opa & issue.opb;
      fu_pkg::BIC:    alu_out = issue.opa & ~issue.opb;
      fu_pkg::BIS:    alu_out = issue.opa | issue.opb;
      fu_pkg::ORNOT:  alu_out = issue.opa | ~issue.opb;
      fu_pkg::XOR:    alu_out = issue.opa ^ issue.opb;
      fu_pkg::EQV:    alu_out = issue.opa ^ ~issue.opb;
      fu_pkg::SRL:    alu_out = issue.opa >> issue.opb[5:0];
      fu_pkg::SLL:    alu_out = issue.opa << issue.opb[5:0];
      fu_pkg::SRA:    alu_out = $signed(issue.opa) >>> issue.opb[5:0];  // sign fill
      fu_pkg::CMPULT: alu_out = {63'd0, issue.opa < issue.opb};
      fu_pkg::CMPEQ:  alu_out = {63'd0, issue.opa == issue.opb};
      fu_pkg::CMPULE: alu_out = {63'd0, issue.opa <= issue.opb};
      fu_pkg::CMPLT:  alu_out = {63'd0, signed_lt(issue.opa, issue.opb)};
      default:        alu_out = {63'd0, signed_lt(issue.opa, issue.opb) ||
                                        issue.opa == issue.opb};  // CMPLE
    endcase
  end

  assign kill_in   = rollback_en && fu_pkg::rob_younger(issue.tag, rollback_idx, rob_tail,
                                                        ROB_DEPTH);
  assign kill_held = rollback_en && fu_pkg::rob_younger(res_tag, rollback_idx, rob_tail,
                                                        ROB_DEPTH);

  assign unit_ready = !result.valid || result.grant;  // empty or leaving now
  assign accept     = issue.valid && issue.kind == fu_pkg::KIND_ALU && unit_ready;

  assign issue.ready[fu_pkg::KIND_ALU] = unit_ready;

  always_ff @(posedge clock) begin
    if (reset)
      res_valid <= 1'b0;
    else if (accept)
      res_valid <= !kill_in;
    else if (result.grant || kill_held)
      res_valid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      res_value <= alu_out;
      res_tag   <= issue.tag;
    end
  end

  assign result.valid = res_valid && !kill_held;  // never offer a squashed result
  assign result.value = res_value;
  assign result.tag   = res_tag;
  assign result.taken = 1'b0;

endmodule

// File: src/mult_stage.sv
`timescale 1ns/10ps

module mult_stage #(
  parameter int MULT_STAGES = fu_pkg::DEFAULT_MULT_STAGES,
  parameter int ROB_DEPTH   = fu_pkg::DEFAULT_ROB_DEPTH
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             advance,
  input  logic             in_valid,
  input  fu_pkg::word_t    in_product,
  input  fu_pkg::word_t    in_mplier,
  input  fu_pkg::word_t    in_mcand,
  input  fu_pkg::rob_idx_t in_tag,
  input  logic             squash_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  input  fu_pkg::rob_idx_t rob_tail,
  output logic             out_valid,
  output fu_pkg::word_t    out_product,
  output fu_pkg::word_t    out_mplier,
  output fu_pkg::word_t    out_mcand,
  output fu_pkg::rob_idx_t out_tag
);

  localparam int CHUNK = 64 / MULT_STAGES;  // multiplier bits per stage

  fu_pkg::word_t partial;
  logic          kill_in;
  logic          kill_out;

  assign partial  = fu_pkg::word_t'(in_mplier[CHUNK-1:0]) * in_mcand;
  assign kill_in  = squash_en && fu_pkg::rob_younger(in_tag, rollback_idx, rob_tail, ROB_DEPTH);
  assign kill_out = squash_en && fu_pkg::rob_younger(out_tag, rollback_idx, rob_tail,
                                                     ROB_DEPTH);

  always_ff @(posedge clock) begin
    if (reset)
      out_valid <= 1'b0;
    else if (advance)
      out_valid <= in_valid && !kill_in;
    else if (kill_out)
      out_valid <= 1'b0;  // stalled but on the wrong path
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      out_product <= in_product + partial;
      out_mplier  <= in_mplier >> CHUNK;   // next chunk to the bottom
      out_mcand   <= in_mcand << CHUNK;    // weight of that chunk
      out_tag     <= in_tag;
    end
  end

endmodule

// File: src/mult_pipe.sv
`timescale 1ns/10ps

module mult_pipe #(
  parameter int MULT_STAGES = fu_pkg::DEFAULT_MULT_STAGES,
  parameter int ROB_DEPTH   = fu_pkg::DEFAULT_ROB_DEPTH
) (
  input  logic             clock,
  input  logic             reset,
  fu_issue_if.unit         issue,
  fu_result_if.unit        result,
  input  logic             rollback_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  input  fu_pkg::rob_idx_t rob_tail
);

  // index 0 is the issue side and index MULT_STAGES the last stage
  logic [MULT_STAGES:0] stage_valid;
  fu_pkg::word_t        product [0:MULT_STAGES];
  fu_pkg::word_t        mplier  [0:MULT_STAGES];
  fu_pkg::word_t        mcand   [0:MULT_STAGES];
  fu_pkg::rob_idx_t     tag     [0:MULT_STAGES];
  logic                 advance;
  logic                 kill_last;

  // whole chain moves together once the tail slot frees up
  assign advance = !result.valid || result.grant;

  assign issue.ready[fu_pkg::KIND_MULT] = advance;

  assign stage_valid[0] = issue.valid && issue.kind == fu_pkg::KIND_MULT && advance;
  assign product[0]     = '0;
  assign mplier[0]      = issue.opa;
  assign mcand[0]       = issue.opb;
  assign tag[0]         = issue.tag;

  for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
    mult_stage #(
      .MULT_STAGES (MULT_STAGES),
      .ROB_DEPTH   (ROB_DEPTH)
    ) u_stage (
      .clock        (clock),
      .reset        (reset),
      .advance      (advance),
      .in_valid     (stage_valid[i]),
      .in_product   (product[i]),
      .in_mplier    (mplier[i]),
      .in_mcand     (mcand[i]),
      .in_tag       (tag[i]),
      .squash_en    (rollback_en),
      .rollback_idx (rollback_idx),
      .rob_tail     (rob_tail),
      .out_valid    (stage_valid[i+1]),
      .out_product  (product[i+1]),
      .out_mplier   (mplier[i+1]),
      .out_mcand    (mcand[i+1]),
      .out_tag      (tag[i+1])
    );
  end

  assign kill_last = rollback_en &&
                     fu_pkg::rob_younger(tag[MULT_STAGES], rollback_idx, rob_tail, ROB_DEPTH);

  assign result.valid = stage_valid[MULT_STAGES] && !kill_last;
  assign result.value = product[MULT_STAGES];  // low 64 bits only
  assign result.tag   = tag[MULT_STAGES];
  assign result.taken = 1'b0;

endmodule

// File: src/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
  input  logic      clock,
  input  logic      reset,
  fu_issue_if.unit  issue,
  fu_result_if.unit result
);

  logic             cond_raw;
  logic             taken;
  logic             unit_ready;
  logic             accept;
  fu_pkg::word_t    target;
  logic             res_valid;
  logic             res_taken;
  fu_pkg::word_t    res_value;
  fu_pkg::rob_idx_t res_tag;

  always_comb begin
    case (issue.br_cond[1:0])
      2'b00:   cond_raw = !issue.opa[0];                       // low bit clear
      2'b01:   cond_raw = issue.opa == '0;                     // equal zero
      2'b10:   cond_raw = issue.opa[63];                       // negative
      default: cond_raw = issue.opa[63] || issue.opa == '0;    // negative or zero
    endcase
  end

  assign taken  = issue.uncond || (cond_raw ^ issue.br_cond[2]);
  assign target = issue.npc + (issue.opb << 2);  // displacement in words

  assign unit_ready = !res_valid || result.grant;
  assign accept     = issue.valid && issue.kind == fu_pkg::KIND_BR && unit_ready;

  assign issue.ready[fu_pkg::KIND_BR] = unit_ready;

  always_ff @(posedge clock) begin
    if (reset)
      res_valid <= 1'b0;
    else if (accept)
      res_valid <= 1'b1;
    else if (result.grant)
      res_valid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      res_taken <= taken;
      res_value <= taken ? target : issue.npc;  // fall through when not taken
      res_tag   <= issue.tag;
    end
  end

  assign result.valid = res_valid;
  assign result.value = res_value;
  assign result.tag   = res_tag;
  assign result.taken = res_taken;

endmodule

// File: src/cdb_arbiter.sv
`timescale 1ns/10ps

module cdb_arbiter (
  input  logic             cdb_ready,
  fu_result_if.arbiter     mult_res,
  fu_result_if.arbiter     br_res,
  fu_result_if.arbiter     alu_res,
  output logic             cdb_valid,
  output fu_pkg::word_t    cdb_value,
  output fu_pkg::rob_idx_t cdb_tag,
  output logic             cdb_taken
);

  // fixed order of multiplier then branch then ALU
  assign mult_res.grant = cdb_ready && mult_res.valid;
  assign br_res.grant   = cdb_ready && br_res.valid && !mult_res.valid;
  assign alu_res.grant  = cdb_ready && alu_res.valid && !mult_res.valid && !br_res.valid;

  assign cdb_valid = mult_res.valid || br_res.valid || alu_res.valid;

  always_comb begin
    if (mult_res.valid) begin
      cdb_value = mult_res.value;
      cdb_tag   = mult_res.tag;
      cdb_taken = mult_res.taken;
    end else if (br_res.valid) begin
      cdb_value = br_res.value;
      cdb_tag   = br_res.tag;
      cdb_taken = br_res.taken;
    end else begin
      cdb_value = alu_res.value;  // also the idle value
      cdb_tag   = alu_res.tag;
      cdb_taken = alu_res.taken;
    end
  end

endmodule

// File: src/fu_cluster.sv
`timescale 1ns/10ps

module fu_cluster #(
  parameter int MULT_STAGES = fu_pkg::DEFAULT_MULT_STAGES,
  parameter int ROB_DEPTH   = fu_pkg::DEFAULT_ROB_DEPTH
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              issue_valid,
  input  fu_pkg::fu_kind_t  issue_kind,
  input  fu_pkg::alu_func_t issue_func,
  input  fu_pkg::br_cond_t  issue_br_cond,
  input  logic              issue_uncond,
  input  fu_pkg::word_t     issue_opa,
  input  fu_pkg::word_t     issue_opb,
  input  fu_pkg::word_t     issue_npc,
  input  fu_pkg::rob_idx_t  issue_tag,
  input  logic              rollback_en,
  input  fu_pkg::rob_idx_t  rollback_idx,
  input  fu_pkg::rob_idx_t  rob_tail,
  input  logic              cdb_ready,
  output logic              issue_ready,
  output logic              cdb_valid,
  output fu_pkg::word_t     cdb_value,
  output fu_pkg::rob_idx_t  cdb_tag,
  output logic              cdb_taken
);

  fu_issue_if  issue_bus ();
  fu_result_if alu_res ();
  fu_result_if mult_res ();
  fu_result_if br_res ();

  // source side of the issue bus
  assign issue_bus.valid   = issue_valid;
  assign issue_bus.kind    = issue_kind;
  assign issue_bus.func    = issue_func;
  assign issue_bus.br_cond = issue_br_cond;
  assign issue_bus.uncond  = issue_uncond;
  assign issue_bus.opa     = issue_opa;
  assign issue_bus.opb     = issue_opb;
  assign issue_bus.npc     = issue_npc;
  assign issue_bus.tag     = issue_tag;

  always_comb begin
    case (issue_kind)
      fu_pkg::KIND_ALU:  issue_ready = issue_bus.ready[fu_pkg::KIND_ALU];
      fu_pkg::KIND_MULT: issue_ready = issue_bus.ready[fu_pkg::KIND_MULT];
      fu_pkg::KIND_BR:   issue_ready = issue_bus.ready[fu_pkg::KIND_BR];
      default:           issue_ready = 1'b0;  // no unit behind this code
    endcase
  end

  alu_unit #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_alu (
    .clock        (clock),
    .reset        (reset),
    .issue        (issue_bus),
    .result       (alu_res),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail     (rob_tail)
  );

  mult_pipe #(
    .MULT_STAGES (MULT_STAGES),
    .ROB_DEPTH   (ROB_DEPTH)
  ) u_mult (
    .clock        (clock),
    .reset        (reset),
    .issue        (issue_bus),
    .result       (mult_res),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail     (rob_tail)
  );

  branch_unit u_br (
    .clock  (clock),
    .reset  (reset),
    .issue  (issue_bus),
    .result (br_res)
  );

  cdb_arbiter u_arb (
    .cdb_ready (cdb_ready),
    .mult_res  (mult_res),
    .br_res    (br_res),
    .alu_res   (alu_res),
    .cdb_valid (cdb_valid),
    .cdb_value (cdb_value),
    .cdb_tag   (cdb_tag),
    .cdb_taken (cdb_taken)
  );

endmodule

// File: bench/fu_ref.svh
`ifndef FU_REF_SVH
`define FU_REF_SVH

// expected ALU result for one operation
function automatic fu_pkg::word_t ref_alu(fu_pkg::alu_func_t func, fu_pkg::word_t a,
                                          fu_pkg::word_t b);
  int unsigned   sh;
  fu_pkg::word_t fill;
  sh   = int'(b[5:0]);
  fill = a[63] ? ~(~64'd0 >> sh) : 64'd0;  // sign copies above the shifted value
  case (func)
    fu_pkg::ADDQ:   return a + b;
    fu_pkg::SUBQ:   return a + ~b + 64'd1;
    fu_pkg::AND:    return a & b;
    fu_pkg::BIC:    return a & ~b;
    fu_pkg::BIS:    return a | b;
    fu_pkg::ORNOT:  return a | ~b;
    fu_pkg::XOR:    return a ^ b;
    fu_pkg::EQV:    return ~(a ^ b);
    fu_pkg::SRL:    return a >> sh;
    fu_pkg::SLL:    return a << sh;
    fu_pkg::SRA:    return (a >> sh) | fill;
    fu_pkg::CMPULT: return fu_pkg::word_t'(a < b);
    fu_pkg::CMPEQ:  return fu_pkg::word_t'(a == b);
    fu_pkg::CMPULE: return fu_pkg::word_t'(!(b < a));
    fu_pkg::CMPLT:  return fu_pkg::word_t'($signed(a) < $signed(b));
    default:        return fu_pkg::word_t'(!($signed(b) < $signed(a)));
  endcase
endfunction

// low half of the full 128-bit product
function automatic fu_pkg::word_t ref_mult(fu_pkg::word_t a, fu_pkg::word_t b);
  logic [127:0] full;
  full = {64'd0, a} * {64'd0, b};
  return full[63:0];
endfunction

function automatic logic ref_br_taken(fu_pkg::br_cond_t cond, logic uncond,
                                      fu_pkg::word_t opa);
  logic test;
  case (cond[1:0])
    2'd0:    test = (opa % 64'd2) == 64'd0;
    2'd1:    test = opa == 64'd0;
    2'd2:    test = $signed(opa) < 0;
    default: test = $signed(opa) <= 0;
  endcase
  return uncond || (cond[2] ? !test : test);
endfunction

function automatic fu_pkg::word_t ref_br_value(logic taken, fu_pkg::word_t npc,
                                               fu_pkg::word_t opb);
  return taken ? npc + opb * 64'd4 : npc;
endfunction

// entry is squashed when it sits no further from the rollback point than the tail
function automatic logic ref_squash(fu_pkg::rob_idx_t tag, fu_pkg::rob_idx_t idx,
                                    fu_pkg::rob_idx_t tail, int depth);
  int tag_age;
  int tail_age;
  tag_age  = int'(tag) - int'(idx);
  tail_age = int'(tail) - int'(idx);
  if (tag_age < 0)
    tag_age = tag_age + depth;
  if (tail_age < 0)
    tail_age = tail_age + depth;
  return tag_age <= tail_age;
endfunction

`endif

// File: bench/fu_cluster_tb.sv
`timescale 1ns/10ps

module fu_cluster_tb;

  localparam int MULT_STAGES = 8;
  localparam int ROB_DEPTH   = 32;
  localparam int LAST        = MULT_STAGES - 1;
  localparam int TOTAL_PKTS  = 32 + 24 + 32 + 8 + 30 + 11;

  `include "fu_ref.svh"

  logic              clock = 1'b0;
  logic              reset;
  logic              issue_valid;
  fu_pkg::fu_kind_t  issue_kind;
  fu_pkg::alu_func_t issue_func;
  fu_pkg::br_cond_t  issue_br_cond;
  logic              issue_uncond;
  fu_pkg::word_t     issue_opa;
  fu_pkg::word_t     issue_opb;
  fu_pkg::word_t     issue_npc;
  fu_pkg::rob_idx_t  issue_tag;
  logic              rollback_en;
  fu_pkg::rob_idx_t  rollback_idx;
  fu_pkg::rob_idx_t  rob_tail;
  logic              cdb_ready;
  logic              issue_ready;
  logic              cdb_valid;
  fu_pkg::word_t     cdb_value;
  fu_pkg::rob_idx_t  cdb_tag;
  logic              cdb_taken;

  // outstanding results by tag
  fu_pkg::word_t    exp_value [fu_pkg::rob_idx_t];
  logic             exp_taken [fu_pkg::rob_idx_t];
  fu_pkg::fu_kind_t exp_kind  [fu_pkg::rob_idx_t];

  // occupancy of the unit output registers and the multiplier chain
  logic             alu_v;
  logic             br_v;
  fu_pkg::rob_idx_t alu_t;
  fu_pkg::rob_idx_t br_t;
  logic             mult_v [MULT_STAGES];
  fu_pkg::rob_idx_t mult_t [MULT_STAGES];

  logic             bp_on;     // random back-pressure on the CDB
  fu_pkg::rob_idx_t next_tag;

  fu_cluster #(
    .MULT_STAGES (MULT_STAGES),
    .ROB_DEPTH   (ROB_DEPTH)
  ) uut (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_kind    (issue_kind),
    .issue_func    (issue_func),
    .issue_br_cond (issue_br_cond),
    .issue_uncond  (issue_uncond),
    .issue_opa     (issue_opa),
    .issue_opb     (issue_opb),
    .issue_npc     (issue_npc),
    .issue_tag     (issue_tag),
    .rollback_en   (rollback_en),
    .rollback_idx  (rollback_idx),
    .rob_tail      (rob_tail),
    .cdb_ready     (cdb_ready),
    .issue_ready   (issue_ready),
    .cdb_valid     (cdb_valid),
    .cdb_value     (cdb_value),
    .cdb_tag       (cdb_tag),
    .cdb_taken     (cdb_taken)
  );

  always #2 clock = ~clock;

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(string name, fu_pkg::word_t got, fu_pkg::word_t exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_tag(string name, fu_pkg::rob_idx_t got, fu_pkg::rob_idx_t exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic fu_pkg::word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic logic model_busy();
    logic busy;
    busy = alu_v || br_v;
    for (int i = 0; i < MULT_STAGES; i++)
      busy = busy || mult_v[i];
    return busy;
  endfunction

  task automatic clear_model();
    alu_v = 1'b0;
    br_v  = 1'b0;
    for (int i = 0; i < MULT_STAGES; i++)
      mult_v[i] = 1'b0;
  endtask

  task automatic shift_mult();
    for (int i = LAST; i > 0; i--) begin
      mult_v[i] = mult_v[i-1];
      mult_t[i] = mult_t[i-1];
    end
    mult_v[0] = 1'b0;
  endtask

  // drop everything on the wrong path except branches
  task automatic apply_rollback();
    fu_pkg::rob_idx_t doomed [$];
    foreach (exp_kind[t])
      if (exp_kind[t] != fu_pkg::KIND_BR && ref_squash(t, rollback_idx, rob_tail, ROB_DEPTH))
        doomed.push_back(t);
    foreach (doomed[i]) begin
      exp_value.delete(doomed[i]);
      exp_taken.delete(doomed[i]);
      exp_kind.delete(doomed[i]);
    end
    if (alu_v && ref_squash(alu_t, rollback_idx, rob_tail, ROB_DEPTH))
      alu_v = 1'b0;
    for (int i = 0; i < MULT_STAGES; i++)
      if (mult_v[i] && ref_squash(mult_t[i], rollback_idx, rob_tail, ROB_DEPTH))
        mult_v[i] = 1'b0;
  endtask

  task automatic take_transfer(fu_pkg::rob_idx_t win_t);
    if (!exp_value.exists(cdb_tag)) begin
      fail_run($sformatf("unexpected tag %0d on the CDB, no result outstanding", cdb_tag));
    end else begin
      check_tag("cdb_tag", cdb_tag, win_t);  // priority order
      check_word("cdb_value", cdb_value, exp_value[cdb_tag]);
      check_bit("cdb_taken", cdb_taken, exp_taken[cdb_tag]);
      exp_value.delete(cdb_tag);
      exp_taken.delete(cdb_tag);
      exp_kind.delete(cdb_tag);
    end
  endtask

  task automatic accept_issue();
    logic             kill;
    fu_pkg::rob_idx_t t;
    t    = issue_tag;
    kill = rollback_en && issue_kind != fu_pkg::KIND_BR &&
           ref_squash(t, rollback_idx, rob_tail, ROB_DEPTH);
    case (issue_kind)
      fu_pkg::KIND_ALU: begin
        alu_v = !kill;
        alu_t = t;
      end
      fu_pkg::KIND_MULT: begin
        mult_v[0] = !kill;
        mult_t[0] = t;
      end
      default: begin
        br_v = 1'b1;
        br_t = t;
      end
    endcase
    if (!kill) begin
      if (exp_kind.exists(t))
        fail_run($sformatf("tag %0d issued again while its result is outstanding", t));
      exp_kind[t]  = issue_kind;
      exp_taken[t] = 1'b0;
      case (issue_kind)
        fu_pkg::KIND_ALU:  exp_value[t] = ref_alu(issue_func, issue_opa, issue_opb);
        fu_pkg::KIND_MULT: exp_value[t] = ref_mult(issue_opa, issue_opb);
        default: begin
          exp_taken[t] = ref_br_taken(issue_br_cond, issue_uncond, issue_opa);
          exp_value[t] = ref_br_value(exp_taken[t], issue_npc, issue_opb);
        end
      endcase
    end
  endtask

  // compare process at mid-cycle when everything is settled
  always @(negedge clock) begin : monitor
    logic             any_v;
    logic             win_v;
    fu_pkg::fu_kind_t win_k;
    fu_pkg::rob_idx_t win_t;
    logic             alu_rdy;
    logic             br_rdy;
    logic             mult_adv;
    logic             exp_rdy;
    if (reset) begin
      clear_model();
    end else begin
      if (rollback_en)
        apply_rollback();
      any_v = mult_v[LAST] || br_v || alu_v;
      win_v = cdb_ready && any_v;
      if (mult_v[LAST]) begin
        win_k = fu_pkg::KIND_MULT;
        win_t = mult_t[LAST];
      end else if (br_v) begin
        win_k = fu_pkg::KIND_BR;
        win_t = br_t;
      end else begin
        win_k = fu_pkg::KIND_ALU;
        win_t = alu_t;
      end
      check_bit("cdb_valid", cdb_valid, any_v);
      if (win_v)
        take_transfer(win_t);
      alu_rdy  = !alu_v || (win_v && win_k == fu_pkg::KIND_ALU);
      br_rdy   = !br_v || (win_v && win_k == fu_pkg::KIND_BR);
      mult_adv = !mult_v[LAST] || (win_v && win_k == fu_pkg::KIND_MULT);
      case (issue_kind)
        fu_pkg::KIND_ALU:  exp_rdy = alu_rdy;
        fu_pkg::KIND_MULT: exp_rdy = mult_adv;
        default:           exp_rdy = br_rdy;
      endcase
      check_bit("issue_ready", issue_ready, exp_rdy);
      if (win_v && win_k == fu_pkg::KIND_ALU)
        alu_v = 1'b0;
      if (win_v && win_k == fu_pkg::KIND_BR)
        br_v = 1'b0;
      if (mult_adv)
        shift_mult();
      if (issue_valid && exp_rdy)
        accept_issue();
    end
  end

  always @(posedge clock) begin
    #1;
    if (bp_on)
      cdb_ready = ($urandom % 3) != 0;
    else
      cdb_ready = 1'b1;
  end

  // holds the packet until the cluster takes it
  task automatic issue_pkt(fu_pkg::fu_kind_t kind, fu_pkg::alu_func_t func,
                           fu_pkg::br_cond_t cond, logic uncond, fu_pkg::word_t opa,
                           fu_pkg::word_t opb, fu_pkg::word_t npc);
    logic accepted;
    issue_valid   = 1'b1;
    issue_kind    = kind;
    issue_func    = func;
    issue_br_cond = cond;
    issue_uncond  = uncond;
    issue_opa     = opa;
    issue_opb     = opb;
    issue_npc     = npc;
    issue_tag     = next_tag;
    rob_tail      = next_tag;
    do begin
      @(negedge clock);
      accepted = issue_ready;
      @(posedge clock);
      #1;
    end while (!accepted);
    issue_valid = 1'b0;
    next_tag    = next_tag + 5'd1;
  endtask

  task automatic begin_test(fu_pkg::rob_idx_t first_tag);
    while (exp_value.num() != 0 || model_busy())
      @(posedge clock);
    repeat (2) @(posedge clock);
    #1;
    next_tag = first_tag;
  endtask

  task automatic run_alu_ops();
    fu_pkg::word_t     a;
    fu_pkg::word_t     b;
    fu_pkg::alu_func_t f;
    begin_test(5'd0);
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < 16; i++) begin
        f = fu_pkg::alu_func_t'(i);
        a = rand_word();
        b = rand_word();
        if (f inside {fu_pkg::SRL, fu_pkg::SLL, fu_pkg::SRA})
          b = (r == 0) ? 64'd63 : (b | 64'd64);
        else if (f == fu_pkg::CMPEQ && r == 1)
          b = a;
        else if (f >= fu_pkg::CMPULT && r == 1) begin
          a[63] = 1'b1;  // signs differ
          b[63] = 1'b0;
        end
        issue_pkt(fu_pkg::KIND_ALU, f, 3'd0, 1'b0, a, b, 64'd0);
      end
    end
  endtask

  task automatic run_mult_ops();
    fu_pkg::word_t a;
    fu_pkg::word_t b;
    begin_test(5'd0);
    for (int i = 0; i < 24; i++) begin
      a = rand_word();
      b = rand_word();
      if (i == 0) begin
        a = '1;
        b = '1;
      end else if (i == 1)
        a = 64'd0;
      else if (i % 5 == 2)
        b = 64'($urandom);  // narrow multiplicand
      issue_pkt(fu_pkg::KIND_MULT, fu_pkg::ADDQ, 3'd0, 1'b0, a, b, 64'd0);
    end
  endtask

  task automatic run_branch_ops();
    fu_pkg::word_t a;
    begin_test(5'd0);
    for (int c = 0; c < 8; c++) begin
      for (int v = 0; v < 4; v++) begin
        case (v)
          0:       a = 64'd0;
          1:       a = rand_word() | 64'h8000_0000_0000_0000;
          2:       a = (rand_word() & 64'h7fff_ffff_ffff_fffe) | 64'd2;  // positive even
          default: a = (rand_word() & 64'h7fff_ffff_ffff_ffff) | 64'd1;
        endcase
        issue_pkt(fu_pkg::KIND_BR, fu_pkg::ADDQ, fu_pkg::br_cond_t'(c), 1'b0, a,
                  rand_word(), rand_word());
      end
    end
    begin_test(5'd0);
    for (int i = 0; i < 8; i++)
      issue_pkt(fu_pkg::KIND_BR, fu_pkg::ADDQ, fu_pkg::br_cond_t'($urandom % 8), 1'b1,
                rand_word(), rand_word(), rand_word());
  endtask

  task automatic run_back_pressure();
    begin_test(5'd0);
    bp_on = 1'b1;
    for (int i = 0; i < 30; i++)
      issue_pkt(fu_pkg::fu_kind_t'($urandom % 3), fu_pkg::alu_func_t'($urandom % 16),
                fu_pkg::br_cond_t'($urandom % 8), ($urandom % 4) == 0, rand_word(),
                rand_word(), rand_word());
    bp_on = 1'b0;
  endtask

  task automatic run_rollback();
    fu_pkg::fu_kind_t seq [10];
    seq = '{fu_pkg::KIND_MULT, fu_pkg::KIND_ALU, fu_pkg::KIND_BR, fu_pkg::KIND_MULT,
            fu_pkg::KIND_MULT, fu_pkg::KIND_ALU, fu_pkg::KIND_MULT, fu_pkg::KIND_BR,
            fu_pkg::KIND_MULT, fu_pkg::KIND_ALU};
    begin_test(5'd26);  // tags wrap past the end of the ROB
    foreach (seq[i])
      issue_pkt(seq[i], fu_pkg::alu_func_t'($urandom % 16), fu_pkg::br_cond_t'($urandom % 8),
                1'b0, rand_word(), rand_word(), rand_word());
    // one-cycle rollback from tag 30 with a younger ALU packet in the same cycle
    rollback_en  = 1'b1;
    rollback_idx = 5'd30;
    rob_tail     = next_tag;
    issue_valid  = 1'b1;
    issue_kind   = fu_pkg::KIND_ALU;
    issue_func   = fu_pkg::ADDQ;
    issue_opa    = rand_word();
    issue_opb    = rand_word();
    issue_tag    = next_tag;
    @(posedge clock);
    #1;
    rollback_en = 1'b0;
    issue_valid = 1'b0;
    next_tag    = next_tag + 5'd1;
  endtask

  initial begin
    void'($urandom(32'h9d718c1c));
    reset         = 1'b1;
    issue_valid   = 1'b0;
    issue_kind    = fu_pkg::KIND_ALU;
    issue_func    = fu_pkg::ADDQ;
    issue_br_cond = 3'd0;
    issue_uncond  = 1'b0;
    issue_opa     = 64'd0;
    issue_opb     = 64'd0;
    issue_npc     = 64'd0;
    issue_tag     = 5'd0;
    rollback_en   = 1'b0;
    rollback_idx  = 5'd0;
    rob_tail      = 5'd0;
    cdb_ready     = 1'b1;
    bp_on         = 1'b0;
    next_tag      = 5'd0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int k = 0; k < 3; k++) begin
      issue_kind = fu_pkg::fu_kind_t'(k);  // ready seen idle for every kind
      @(posedge clock);
      #1;
    end
    run_alu_ops();
    run_mult_ops();
    run_branch_ops();
    run_back_pressure();
    run_rollback();
    begin_test(5'd0);
    if (exp_value.num() == 0 && !model_busy()) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_run("results still outstanding at the end of the run");
    end
  end

  initial begin
    repeat (TOTAL_PKTS * 200 + 1000) @(posedge clock);
    fail_run("timeout: the run did not finish within its cycle budget");
  end

endmodule

// File: src.f
+incdir+bench
src/fu_pkg.sv
src/fu_issue_if.sv
src/fu_result_if.sv
src/alu_unit.sv
src/mult_stage.sv
src/mult_pipe.sv
src/branch_unit.sv
src/cdb_arbiter.sv
src/fu_cluster.sv
bench/fu_cluster_tb.sv

// File: Makefile
# Verilator build and run of the execution cluster testbench

VERILATOR ?= verilator
TOP       ?= fu_cluster_tb
DUT_TOP   ?= fu_cluster
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
